// ==== src/cache_pkg.sv ====
// fixed geometry of 4 ways x 8 sets x 32-byte lines on a 32-bit byte address; mux literals are prefixed to stay unique
`default_nettype none

package cache_pkg;

    // address split is tag | index | offset
    localparam int ADDR_BITS   = 32;
    localparam int TAG_BITS    = 24;
    localparam int INDEX_BITS  = 3;
    localparam int OFFSET_BITS = 5;

    localparam int NUM_WAYS  = 4;
    localparam int WAY_BITS  = 2;
    localparam int NUM_SETS  = 8;
    localparam int LINE_BITS = 256;
    localparam int MBE_BITS  = 32;

    // tree bits per set, bit0 is the root
    localparam int LRU_BITS = 3;

    // controller states
    typedef enum logic [1:0] {
        hit_check,
        write_back,
        read_back
    } state_t;

    // source of the line written into the data array
    typedef enum logic {
        di_from_cpu,
        di_from_pmem
    } dimux_sel_t;

    // way driven onto the line output
    typedef enum logic [1:0] {
        do_way_0,
        do_way_1,
        do_way_2,
        do_way_3
    } domux_sel_t;

    // physical address source, a victim tag or the cpu tag
    typedef enum logic [2:0] {
        addr_way_0,
        addr_way_1,
        addr_way_2,
        addr_way_3,
        addr_from_cpu
    } addrmux_sel_t;

    // byte write pattern for one way
    typedef enum logic [1:0] {
        we_none,
        we_all,
        we_mbe
    } wemux_sel_t;

endpackage

`default_nettype wire

// ==== src/cache_ctrl_if.sv ====
// control to datapath bundle; status bits always reflect the set indexed by the current cpu address
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if;

    // selects from the controller
    cache_pkg::dimux_sel_t   dimux_sel;
    cache_pkg::domux_sel_t   domux_sel;
    cache_pkg::addrmux_sel_t addrmux_sel;
    cache_pkg::wemux_sel_t   wemux_sel [cache_pkg::NUM_WAYS];

    // per-way loads and the values they store
    logic [cache_pkg::NUM_WAYS-1:0] tag_load;
    logic [cache_pkg::NUM_WAYS-1:0] valid_load;
    logic [cache_pkg::NUM_WAYS-1:0] valid_in;
    logic [cache_pkg::NUM_WAYS-1:0] dirty_load;
    logic [cache_pkg::NUM_WAYS-1:0] dirty_in;

    logic                           lru_load;
    logic [cache_pkg::WAY_BITS-1:0] lru_way;

    // status back from the arrays
    logic [cache_pkg::NUM_WAYS-1:0] hit;
    logic [cache_pkg::NUM_WAYS-1:0] valid;
    logic [cache_pkg::NUM_WAYS-1:0] dirty;
    logic [cache_pkg::LRU_BITS-1:0] lru;

    modport control (
        output dimux_sel, domux_sel, addrmux_sel, wemux_sel,
        output tag_load, valid_load, valid_in, dirty_load, dirty_in,
        output lru_load, lru_way,
        input  hit, valid, dirty, lru
    );

    modport datapath (
        input  dimux_sel, domux_sel, addrmux_sel, wemux_sel,
        input  tag_load, valid_load, valid_in, dirty_load, dirty_in,
        input  lru_load, lru_way,
        output hit, valid, dirty, lru
    );

endinterface

`default_nettype wire

// ==== src/cache_control.sv ====
// blocking miss controller, one request at a time; cpu and pmem strobes must be held until their response pulse
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  logic clk,
    input  logic rst,
    input  logic mem_read_i,
    input  logic mem_write_i,
    input  logic pmem_resp_i,
    output logic mem_resp_o,
    output logic pmem_read_o,
    output logic pmem_write_o,
    cache_ctrl_if.control ctrl
);

    cache_pkg::state_t state_q;
    cache_pkg::state_t state_d;

    logic [cache_pkg::WAY_BITS-1:0] hit_way;
    logic [cache_pkg::WAY_BITS-1:0] victim_way;
    logic                           req;

    assign req = mem_read_i | mem_write_i;

    // one-hot hit vector to way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (ctrl.hit[w]) begin
                hit_way = w[cache_pkg::WAY_BITS-1:0];
            end
        end
    end

    // root bit set walks the tree to the left pair
    always_comb begin
        if (ctrl.lru[0]) begin
            victim_way = ctrl.lru[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = ctrl.lru[2] ? 2'd2 : 2'd3;
        end
    end

    always_comb begin
        // idle defaults
        ctrl.dimux_sel   = cache_pkg::di_from_cpu;
        ctrl.domux_sel   = cache_pkg::do_way_0;
        ctrl.addrmux_sel = cache_pkg::addr_from_cpu;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            ctrl.wemux_sel[w] = cache_pkg::we_none;
        end
        ctrl.tag_load   = '0;
        ctrl.valid_load = '0;
        ctrl.valid_in   = '0;
        ctrl.dirty_load = '0;
        ctrl.dirty_in   = '0;
        ctrl.lru_load   = 1'b0;
        ctrl.lru_way    = hit_way;
        mem_resp_o      = 1'b0;
        pmem_read_o     = 1'b0;
        pmem_write_o    = 1'b0;
        state_d         = state_q;

        case (state_q)
            cache_pkg::hit_check: begin
                if (req && (ctrl.hit != '0)) begin
                    mem_resp_o     = 1'b1;
                    ctrl.lru_load  = 1'b1;
                    ctrl.domux_sel = cache_pkg::domux_sel_t'(hit_way);
                    if (mem_write_i) begin
                        ctrl.dimux_sel           = cache_pkg::di_from_cpu;
                        ctrl.wemux_sel[hit_way]  = cache_pkg::we_mbe;
                        ctrl.dirty_load[hit_way] = 1'b1;
                        ctrl.dirty_in[hit_way]   = 1'b1;
                    end
                end else if (req) begin
                    // only a valid dirty victim needs writing out first
                    if (ctrl.valid[victim_way] && ctrl.dirty[victim_way]) begin
                        state_d = cache_pkg::write_back;
                    end else begin
                        state_d = cache_pkg::read_back;
                    end
                end
            end

            cache_pkg::write_back: begin
                pmem_write_o     = 1'b1;
                ctrl.domux_sel   = cache_pkg::domux_sel_t'(victim_way);
                ctrl.addrmux_sel = cache_pkg::addrmux_sel_t'({1'b0, victim_way});
                if (pmem_resp_i) begin
                    state_d = cache_pkg::read_back;
                end
            end

            cache_pkg::read_back: begin
                // line is rewritten every cycle and the response cycle leaves the right data
                pmem_read_o                 = 1'b1;
                ctrl.addrmux_sel            = cache_pkg::addr_from_cpu;
                ctrl.dimux_sel              = cache_pkg::di_from_pmem;
                ctrl.wemux_sel[victim_way]  = cache_pkg::we_all;
                ctrl.tag_load[victim_way]   = 1'b1;
                ctrl.valid_load[victim_way] = 1'b1;
                ctrl.valid_in[victim_way]   = 1'b1;
                ctrl.dirty_load[victim_way] = 1'b1;
                ctrl.dirty_in[victim_way]   = 1'b0;
                if (pmem_resp_i) begin
                    state_d = cache_pkg::hit_check;
                end
            end

            default: begin
                state_d = cache_pkg::hit_check;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= cache_pkg::hit_check;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_tag_array.sv ====
// stored tags mean nothing until their valid bit is set; pmem address always has a zero line offset
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_address_i,
    output logic [31:0] pmem_address_o,
    cache_ctrl_if.datapath dp
);

    logic [cache_pkg::TAG_BITS-1:0]   tag_q [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0]   valid_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0]   dirty_q [cache_pkg::NUM_SETS];

    logic [cache_pkg::TAG_BITS-1:0]   addr_tag;
    logic [cache_pkg::INDEX_BITS-1:0] index;
    logic [cache_pkg::TAG_BITS-1:0]   pmem_tag;

    assign addr_tag = mem_address_i[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
    assign index    = mem_address_i[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];

    // valid and dirty per set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                if (dp.valid_load[w]) begin
                    valid_q[index][w] <= dp.valid_in[w];
                end
                if (dp.dirty_load[w]) begin
                    dirty_q[index][w] <= dp.dirty_in[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (dp.tag_load[w]) begin
                tag_q[w][index] <= addr_tag;
            end
        end
    end

    // hit compare against the indexed set
    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            dp.hit[w] = valid_q[index][w] && (tag_q[w][index] == addr_tag);
        end
    end

    assign dp.valid = valid_q[index];
    assign dp.dirty = dirty_q[index];

    // victim tag for write back, cpu tag for fill
    always_comb begin
        case (dp.addrmux_sel)
            cache_pkg::addr_way_0: pmem_tag = tag_q[0][index];
            cache_pkg::addr_way_1: pmem_tag = tag_q[1][index];
            cache_pkg::addr_way_2: pmem_tag = tag_q[2][index];
            cache_pkg::addr_way_3: pmem_tag = tag_q[3][index];
            default:               pmem_tag = addr_tag;
        endcase
    end

    assign pmem_address_o = {pmem_tag, index, {cache_pkg::OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

// ==== src/cache_data_array.sv ====
// line contents are undefined until filled; one line out feeds both cpu and pmem
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
    input  logic         clk,
    input  logic [31:0]  mem_address_i,
    input  logic [255:0] mem_wdata_i,
    input  logic [31:0]  mem_byte_enable_i,
    input  logic [255:0] pmem_rdata_i,
    output logic [255:0] mem_rdata_o,
    output logic [255:0] pmem_wdata_o,
    cache_ctrl_if.datapath dp
);

    logic [cache_pkg::LINE_BITS-1:0]  line_q [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

    logic [cache_pkg::INDEX_BITS-1:0] index;
    logic [cache_pkg::LINE_BITS-1:0]  line_in;
    logic [cache_pkg::LINE_BITS-1:0]  line_out;
    logic [cache_pkg::MBE_BITS-1:0]   way_be [cache_pkg::NUM_WAYS];

    assign index = mem_address_i[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];

    // data in mux
    assign line_in = (dp.dimux_sel == cache_pkg::di_from_pmem) ? pmem_rdata_i : mem_wdata_i;

    // byte enables per way
    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            case (dp.wemux_sel[w])
                cache_pkg::we_all: way_be[w] = '1;
                cache_pkg::we_mbe: way_be[w] = mem_byte_enable_i;
                default:           way_be[w] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            for (int b = 0; b < cache_pkg::MBE_BITS; b++) begin
                if (way_be[w][b]) begin
                    line_q[w][index][8*b +: 8] <= line_in[8*b +: 8];
                end
            end
        end
    end

    // way select on the output side
    assign line_out = line_q[dp.domux_sel][index];

    assign mem_rdata_o  = line_out;
    assign pmem_wdata_o = line_out;

endmodule

`default_nettype wire

// ==== src/cache_plru.sv ====
// tree pseudo-LRU, one update per hit response; a cleared tree names way 3 as the first victim
`timescale 1ns/1ps
`default_nettype none

module cache_plru (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_address_i,
    cache_ctrl_if.datapath dp
);

    logic [cache_pkg::LRU_BITS-1:0]   lru_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::INDEX_BITS-1:0] index;

    assign index  = mem_address_i[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
    assign dp.lru = lru_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                lru_q[s] <= '0;
            end
        end else if (dp.lru_load) begin
            // point the tree away from the used way and keep the other subtree bit
            case (dp.lru_way)
                2'd0: begin
                    lru_q[index][0] <= 1'b0;
                    lru_q[index][1] <= 1'b0;
                end
                2'd1: begin
                    lru_q[index][0] <= 1'b0;
                    lru_q[index][1] <= 1'b1;
                end
                2'd2: begin
                    lru_q[index][0] <= 1'b1;
                    lru_q[index][2] <= 1'b0;
                end
                default: begin
                    lru_q[index][0] <= 1'b1;
                    lru_q[index][2] <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cache.sv ====
// 4-way write-back cache top; requests are served one at a time and only whole 256-bit lines move
`timescale 1ns/1ps
`default_nettype none

module cache (
    input  logic         clk,
    input  logic         rst,

    // cpu side
    input  logic [31:0]  mem_address_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  logic [31:0]  mem_byte_enable_i,
    input  logic [255:0] mem_wdata_i,
    output logic [255:0] mem_rdata_o,
    output logic         mem_resp_o,

    // physical memory side
    output logic [31:0]  pmem_address_o,
    output logic         pmem_read_o,
    output logic         pmem_write_o,
    output logic [255:0] pmem_wdata_o,
    input  logic [255:0] pmem_rdata_i,
    input  logic         pmem_resp_i
);

    cache_ctrl_if ctrl_bus ();

    cache_control u_control (
        .clk          (clk),
        .rst          (rst),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .pmem_resp_i  (pmem_resp_i),
        .mem_resp_o   (mem_resp_o),
        .pmem_read_o  (pmem_read_o),
        .pmem_write_o (pmem_write_o),
        .ctrl         (ctrl_bus.control)
    );

    cache_tag_array u_tag_array (
        .clk            (clk),
        .rst            (rst),
        .mem_address_i  (mem_address_i),
        .pmem_address_o (pmem_address_o),
        .dp             (ctrl_bus.datapath)
    );

    cache_data_array u_data_array (
        .clk               (clk),
        .mem_address_i     (mem_address_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .pmem_rdata_i      (pmem_rdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .pmem_wdata_o      (pmem_wdata_o),
        .dp                (ctrl_bus.datapath)
    );

    cache_plru u_plru (
        .clk           (clk),
        .rst           (rst),
        .mem_address_i (mem_address_i),
        .dp            (ctrl_bus.datapath)
    );

endmodule

`default_nettype wire

// ==== tb/tb_cache.sv ====
// one request at a time from the golden file; memory latency and idle gaps are random from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int NUM_OPS    = 21;
    localparam int MAX_CYCLES = RST_CYCLES + 40 * NUM_OPS;
    localparam logic [31:0] SEED = 32'h66eab7e3;

    logic         clk;
    logic         rst;
    logic [31:0]  mem_address_i;
    logic         mem_read_i;
    logic         mem_write_i;
    logic [31:0]  mem_byte_enable_i;
    logic [255:0] mem_wdata_i;
    logic [255:0] mem_rdata_o;
    logic         mem_resp_o;
    logic [31:0]  pmem_address_o;
    logic         pmem_read_o;
    logic         pmem_write_o;
    logic [255:0] pmem_wdata_o;
    logic [255:0] pmem_rdata_i;
    logic         pmem_resp_i;

    // op | address | byte enable | data | expected word | pmem writes | pmem reads
    logic [139:0] golden [NUM_OPS];
    // written-back lines keyed by line address
    logic [255:0] line_store [logic [31:0]];

    int checks;
    int errors;
    int cycles;
    int wr_count;
    int rd_count;
    int mem_delay;

    cache UUT (
        .clk               (clk),
        .rst               (rst),
        .mem_address_i     (mem_address_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_resp_o        (mem_resp_o),
        .pmem_address_o    (pmem_address_o),
        .pmem_read_o       (pmem_read_o),
        .pmem_write_o      (pmem_write_o),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_resp_i       (pmem_resp_i)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // contents of a line that was never written back
    function automatic logic [255:0] rule_line(input logic [31:0] line_addr);
        logic [255:0] line;
        for (int k = 0; k < 8; k++) begin
            line[32*k +: 32] = line_addr ^ 32'(k) ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs_idle();
        check_value("mem_resp_o", 32'd0, 32'(mem_resp_o));
        check_value("pmem_read_o", 32'd0, 32'(pmem_read_o));
        check_value("pmem_write_o", 32'd0, 32'(pmem_write_o));
    endtask

    task automatic serve_strobe();
        if (pmem_write_o) begin
            // a dirty victim goes out before the fill is read
            check_value("pmem reads before write back", 32'd0, 32'(rd_count));
            line_store[pmem_address_o] = pmem_wdata_o;
            wr_count++;
        end else begin
            if (line_store.exists(pmem_address_o)) begin
                pmem_rdata_i = line_store[pmem_address_o];
            end else begin
                pmem_rdata_i = rule_line(pmem_address_o);
            end
            rd_count++;
        end
        pmem_resp_i = 1'b1;
    endtask

    // physical memory model answers a held strobe after 1 to 4 cycles
    always @(negedge clk) begin
        if (rst) begin
            pmem_resp_i = 1'b0;
            mem_delay   = 0;
        end else if (pmem_resp_i) begin
            pmem_resp_i = 1'b0;
        end else if (pmem_read_o || pmem_write_o) begin
            if (mem_delay == 0) begin
                mem_delay = 1 + int'($urandom % 4);
            end
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                serve_strobe();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the cache gave no response within %0d cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic [139:0] entry;
        logic [31:0]  addr;
        logic [255:0] rdata;
        logic         got_resp;
        logic [31:0]  seed_init;
        int           idle;
        int           wait_cycles;

        checks            = 0;
        errors            = 0;
        cycles            = 0;
        wr_count          = 0;
        rd_count          = 0;
        mem_delay         = 0;
        seed_init         = $urandom(SEED);
        clk               = 1'b0;
        rst               = 1'b1;
        mem_address_i     = '0;
        mem_read_i        = 1'b0;
        mem_write_i       = 1'b0;
        mem_byte_enable_i = '0;
        mem_wdata_i       = '0;
        pmem_rdata_i      = '0;
        pmem_resp_i       = 1'b0;
        $readmemh("tb/cache_golden.txt", golden);

        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_outputs_idle();
        end
        rst = 1'b0;
        @(negedge clk);
        check_outputs_idle();

        for (int i = 0; i < NUM_OPS; i++) begin
            entry = golden[i];
            addr  = entry[135:104];
            idle  = int'($urandom % 4);
            repeat (idle) @(negedge clk);
            wr_count      = 0;
            rd_count      = 0;
            mem_address_i = addr;
            if (entry[139:136] == 4'h1) begin
                mem_write_i       = 1'b1;
                mem_byte_enable_i = entry[103:72];
                mem_wdata_i       = {8{entry[71:40]}};
            end else begin
                mem_read_i = 1'b1;
            end

            // sample in the middle of the low phase before the rising edge that takes it
            got_resp    = 1'b0;
            wait_cycles = 0;
            while (!got_resp) begin
                #(CLK_PERIOD/4);
                wait_cycles++;
                if (mem_resp_o) begin
                    got_resp = 1'b1;
                    rdata    = mem_rdata_o;
                end
                @(negedge clk);
            end
            mem_read_i  = 1'b0;
            mem_write_i = 1'b0;

            check_value("pmem_write count", 32'(entry[7:4]), wr_count);
            check_value("pmem_read count", 32'(entry[3:0]), rd_count);
            if (entry[7:0] == 8'h00) begin
                // a hit answers in the cycle the request first appears
                check_value("hit response cycle", 32'd1, 32'(wait_cycles));
            end
            if (entry[139:136] != 4'h1) begin
                check_value("mem_rdata_o word", entry[39:8], rdata[32*addr[4:2] +: 32]);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cache_golden.txt ====
// op (1 write, 0 read) _ address _ byte enable _ write data _ expected word _ pmem writes _ pmem reads
// byte enable and data are unused by reads, the expected word is unused by writes
0_00001004_00000000_00000000_5a5a1001_0_1
0_00001004_00000000_00000000_5a5a1001_0_0
1_00001008_00000500_a1b2c3d4_00000000_0_0
0_00001008_00000000_00000000_5ab210d4_0_0
// five tags in set 1, the fifth evicts way 3
0_00010020_00000000_00000000_5a5b0020_0_1
0_00020024_00000000_00000000_5a580021_0_1
0_00030028_00000000_00000000_5a590022_0_1
0_0004003c_00000000_00000000_5a5e0027_0_1
0_00050020_00000000_00000000_5a5f0020_0_1
0_00020024_00000000_00000000_5a580021_0_0
0_00010020_00000000_00000000_5a5b0020_0_1
0_0004003c_00000000_00000000_5a5e0027_0_0
// set 0 misses until the dirty line is written back
0_00002000_00000000_00000000_5a5a2000_0_1
0_00003000_00000000_00000000_5a5a3000_0_1
0_00004000_00000000_00000000_5a5a4000_0_1
0_00005000_00000000_00000000_5a5a5000_1_1
0_00001008_00000000_00000000_5ab210d4_0_1
0_00001004_00000000_00000000_5a5a1001_0_0
// write miss in set 2
1_00006040_0000000f_12345678_00000000_0_1
0_00006040_00000000_00000000_12345678_0_0
0_00006044_00000000_00000000_5a5a6041_0_0

// ==== filelist.f ====
src/cache_pkg.sv
src/cache_ctrl_if.sv
src/cache_control.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_plru.sv
src/cache.sv
tb/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cache -f filelist.f -Mdir obj_dir
./obj_dir/Vtb_cache > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
